//--- la_regmap_pkg.sv
package la_regmap_pkg;

    localparam int ADDR_W = 12;

    localparam logic [ADDR_W-1:0] REG_CTRL    = 12'h000; // bit 0 set arms, clear aborts
    localparam logic [ADDR_W-1:0] REG_MODE    = 12'h004; // bit 0: 0 is AND, 1 is OR
    localparam logic [ADDR_W-1:0] REG_DEPTH   = 12'h008; // capture length minus one
    localparam logic [ADDR_W-1:0] REG_PRE     = 12'h00C; // pre-trigger samples, at most DEPTH
    localparam logic [ADDR_W-1:0] REG_DIV     = 12'h010; // one sample every DIV+1 clocks
    localparam logic [ADDR_W-1:0] REG_STATUS  = 12'h014; // read only, {done, triggered, busy}

    // one condition word per channel, channel c at REG_CH_BASE + 4*c
    localparam logic [ADDR_W-1:0] REG_CH_BASE = 12'h040;

    // capture window, word i at BUF_BASE + 4*i, oldest sample first
    localparam logic [ADDR_W-1:0] BUF_BASE    = 12'h400;

endpackage

//--- la_capture_pkg.sv
package la_capture_pkg;

    localparam int N_CH     = 8;
    localparam int SAMPLE_W = 8;
    localparam int BUF_AW   = 8; // 256 sample buffer

    // per-channel trigger condition, codes 6 and 7 act as ignore
    typedef logic [2:0] trig_op_t;

    localparam trig_op_t OP_IGNORE  = 3'd0;
    localparam trig_op_t OP_LOW     = 3'd1;
    localparam trig_op_t OP_HIGH    = 3'd2;
    localparam trig_op_t OP_RISING  = 3'd3;
    localparam trig_op_t OP_FALLING = 3'd4;
    localparam trig_op_t OP_ANYEDGE = 3'd5;

    typedef enum logic [2:0] {
        IDLE,
        FILL,  // storing the pre-trigger window
        ARMED, // window full, waiting for the trigger sample
        POST,
        DONE
    } cap_state_t;

endpackage

//--- apb_regs.sv
`timescale 1ns/1ps
module apb_regs (
    input  logic                                                     clk,
    input  logic                                                     arst_n,
    input  logic                                                     psel,
    input  logic                                                     penable,
    input  logic                                                     pwrite,
    input  logic [la_regmap_pkg::ADDR_W-1:0]                         paddr,
    input  logic [31:0]                                              pwdata,
    output logic [31:0]                                              prdata,
    output logic                                                     pready,
    output logic                                                     pslverr,
    output logic                                                     arm,
    output logic                                                     abort,
    output logic                                                     mode,
    output logic [la_capture_pkg::SAMPLE_W-1:0]                      depth,
    output logic [la_capture_pkg::SAMPLE_W-1:0]                      pre,
    output logic [la_capture_pkg::SAMPLE_W-1:0]                      div,
    output la_capture_pkg::trig_op_t [la_capture_pkg::N_CH-1:0]      ch_ops,
    input  logic                                                     busy,
    input  logic                                                     triggered,
    input  logic                                                     done,
    input  logic [la_capture_pkg::BUF_AW-1:0]                        start_ptr,
    output logic                                                     rd_en,
    output logic [la_capture_pkg::BUF_AW-1:0]                        rd_addr,
    input  logic [la_capture_pkg::SAMPLE_W-1:0]                      rd_data
);

    logic        setup;
    logic        access;
    logic        aligned;
    logic        in_buf;
    logic        in_ch;
    logic        buf_rd;
    logic        mapped;
    logic        err;
    logic        wr_fire;
    logic        ctrl;
    logic [31:0] reg_rdata;

    assign setup   = psel & ~penable;
    assign access  = psel & penable;
    assign aligned = paddr[1:0] == 2'b00;
    assign in_buf  = paddr[11:10] == la_regmap_pkg::BUF_BASE[11:10]; // 0x400 to 0x7FC
    assign in_ch   = paddr[11:5] == la_regmap_pkg::REG_CH_BASE[11:5];
    assign buf_rd  = in_buf & ~pwrite;
    assign wr_fire = access & pready & pwrite & ~pslverr; // write lands on completion

    // window words are relative to the oldest sample of the capture
    assign rd_en   = setup & buf_rd;
    assign rd_addr = start_ptr + paddr[la_capture_pkg::BUF_AW+1:2];

    always_comb begin
        reg_rdata = '0;
        mapped    = 1'b1;
        if (in_ch) begin
            reg_rdata[2:0] = ch_ops[paddr[4:2]];
            mapped         = aligned;
        end else begin
            case (paddr)
                la_regmap_pkg::REG_CTRL:   reg_rdata[0]   = ctrl;
                la_regmap_pkg::REG_MODE:   reg_rdata[0]   = mode;
                la_regmap_pkg::REG_DEPTH:  reg_rdata[7:0] = depth;
                la_regmap_pkg::REG_PRE:    reg_rdata[7:0] = pre;
                la_regmap_pkg::REG_DIV:    reg_rdata[7:0] = div;
                la_regmap_pkg::REG_STATUS: reg_rdata[2:0] = {done, triggered, busy};
                default:                   mapped = in_buf & aligned;
            endcase
        end
    end

    assign err = ~mapped | (pwrite & (in_buf | paddr == la_regmap_pkg::REG_STATUS));

    // registers answer in the first access cycle, buffer reads one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end else begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            if (setup && !buf_rd) begin
                pready  <= 1'b1;
                pslverr <= err;
                prdata  <= err ? '0 : reg_rdata;
            end else if (access && buf_rd && !pready) begin
                pready  <= 1'b1;
                pslverr <= busy | ~aligned; // the window is not stable while capturing
                prdata  <= 32'(rd_data);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arm    <= 1'b0;
            abort  <= 1'b0;
            ctrl   <= 1'b0;
            mode   <= 1'b0;
            depth  <= '0;
            pre    <= '0;
            div    <= '0;
            ch_ops <= {la_capture_pkg::N_CH{la_capture_pkg::OP_IGNORE}};
        end else begin
            arm   <= wr_fire && paddr == la_regmap_pkg::REG_CTRL && pwdata[0];
            abort <= wr_fire && paddr == la_regmap_pkg::REG_CTRL && !pwdata[0];
            if (wr_fire && in_ch) begin
                ch_ops[paddr[4:2]] <= la_capture_pkg::trig_op_t'(pwdata[2:0]);
            end
            if (wr_fire) begin
                case (paddr)
                    la_regmap_pkg::REG_CTRL:  ctrl  <= pwdata[0];
                    la_regmap_pkg::REG_MODE:  mode  <= pwdata[0];
                    la_regmap_pkg::REG_DEPTH: depth <= pwdata[7:0];
                    la_regmap_pkg::REG_PRE:   pre   <= pwdata[7:0];
                    la_regmap_pkg::REG_DIV:   div   <= pwdata[7:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- sample_divider.sv
`timescale 1ns/1ps
module sample_divider (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                run,
    input  logic [la_capture_pkg::SAMPLE_W-1:0] div,
    output logic                                sample_stb
);

    logic [la_capture_pkg::SAMPLE_W-1:0] cnt;

    // strobe on the first clock of run, then every div+1 clocks
    assign sample_stb = run & (cnt == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0; // restart the period on the next run
        end else if (cnt == '0) begin
            cnt <= div;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- trigger_unit.sv
`timescale 1ns/1ps
module trigger_unit (
    input  logic                                                clk,
    input  logic                                                arst_n,
    input  logic                                                sample_stb,
    input  logic [la_capture_pkg::SAMPLE_W-1:0]                 digital_in,
    input  la_capture_pkg::trig_op_t [la_capture_pkg::N_CH-1:0] ch_ops,
    input  logic                                                mode,
    output logic [la_capture_pkg::SAMPLE_W-1:0]                 sample,
    output logic                                                sample_valid,
    output logic                                                hit
);

    logic [la_capture_pkg::SAMPLE_W-1:0] prev;
    logic [la_capture_pkg::N_CH-1:0]     match;
    logic [la_capture_pkg::N_CH-1:0]     active;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= sample_stb;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_stb) begin
            sample <= digital_in;
            prev   <= sample; // edges compare against the sample before
        end
    end

    always_comb begin
        for (int c = 0; c < la_capture_pkg::N_CH; c++) begin
            active[c] = 1'b1;
            match[c]  = 1'b0;
            case (ch_ops[c])
                la_capture_pkg::OP_LOW:     match[c] = ~sample[c];
                la_capture_pkg::OP_HIGH:    match[c] = sample[c];
                la_capture_pkg::OP_RISING:  match[c] = sample[c] & ~prev[c];
                la_capture_pkg::OP_FALLING: match[c] = ~sample[c] & prev[c];
                la_capture_pkg::OP_ANYEDGE: match[c] = sample[c] ^ prev[c];
                default:                    active[c] = 1'b0; // ignored channel
            endcase
        end
    end

    // with no active channel AND gives 1 and OR gives 0
    assign hit = mode ? |(match & active) : &(match | ~active);

endmodule

//--- capture_fsm.sv
`timescale 1ns/1ps
module capture_fsm (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                arm,
    input  logic                                abort,
    input  logic [la_capture_pkg::SAMPLE_W-1:0] depth,
    input  logic [la_capture_pkg::SAMPLE_W-1:0] pre,
    input  logic                                sample_valid,
    input  logic                                hit,
    output logic                                run,
    output logic                                wr_en,
    output logic [la_capture_pkg::BUF_AW-1:0]   wr_addr,
    output logic                                busy,
    output logic                                triggered,
    output logic                                done,
    output logic [la_capture_pkg::BUF_AW-1:0]   start_ptr
);

    la_capture_pkg::cap_state_t          state;
    logic [la_capture_pkg::SAMPLE_W-1:0] cnt; // samples stored, then samples still to come
    logic [la_capture_pkg::SAMPLE_W-1:0] pre_min;
    logic [la_capture_pkg::BUF_AW-1:0]   trig_addr;

    assign pre_min   = (pre == '0) ? la_capture_pkg::SAMPLE_W'(1) : pre;
    assign busy      = state inside {la_capture_pkg::FILL, la_capture_pkg::ARMED,
                                     la_capture_pkg::POST};
    assign run       = busy;
    assign triggered = state inside {la_capture_pkg::POST, la_capture_pkg::DONE};
    assign done      = state == la_capture_pkg::DONE;
    assign wr_en     = sample_valid & busy; // write in the cycle the sample appears
    assign start_ptr = trig_addr - la_capture_pkg::BUF_AW'(pre);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= la_capture_pkg::IDLE;
            wr_addr   <= '0;
            cnt       <= '0;
            trig_addr <= '0;
        end else if (abort) begin
            state <= la_capture_pkg::IDLE;
        end else if (arm) begin
            state   <= la_capture_pkg::FILL; // a new arm restarts from any state
            wr_addr <= '0;
            cnt     <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1; // circular buffer wraps at 256
            case (state)
                la_capture_pkg::FILL: begin
                    cnt <= cnt + 1'b1;
                    if (cnt + 1'b1 >= pre_min) begin
                        state <= la_capture_pkg::ARMED;
                    end
                end
                la_capture_pkg::ARMED: begin
                    if (hit) begin
                        trig_addr <= wr_addr;
                        cnt       <= depth - pre;
                        state     <= (depth == pre) ? la_capture_pkg::DONE
                                                    : la_capture_pkg::POST;
                    end
                end
                la_capture_pkg::POST: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == la_capture_pkg::SAMPLE_W'(1)) begin
                        state <= la_capture_pkg::DONE;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- sample_ram.sv
`timescale 1ns/1ps
module sample_ram (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic [la_capture_pkg::BUF_AW-1:0]   wr_addr,
    input  logic [la_capture_pkg::SAMPLE_W-1:0] wr_data,
    input  logic                                rd_en,
    input  logic [la_capture_pkg::BUF_AW-1:0]   rd_addr,
    output logic [la_capture_pkg::SAMPLE_W-1:0] rd_data
);

    logic [la_capture_pkg::SAMPLE_W-1:0] mem [2**la_capture_pkg::BUF_AW];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one clock of read latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- logic_analyzer.sv
`timescale 1ns/1ps
module logic_analyzer (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [la_capture_pkg::SAMPLE_W-1:0] digital_in,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [la_regmap_pkg::ADDR_W-1:0]    paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                done_irq
);

    logic                                                arm;
    logic                                                abort;
    logic                                                mode;
    logic [la_capture_pkg::SAMPLE_W-1:0]                 depth;
    logic [la_capture_pkg::SAMPLE_W-1:0]                 pre;
    logic [la_capture_pkg::SAMPLE_W-1:0]                 div;
    la_capture_pkg::trig_op_t [la_capture_pkg::N_CH-1:0] ch_ops;
    logic                                                busy;
    logic                                                triggered;
    logic                                                done;
    logic [la_capture_pkg::BUF_AW-1:0]                   start_ptr;
    logic                                                rd_en;
    logic [la_capture_pkg::BUF_AW-1:0]                   rd_addr;
    logic [la_capture_pkg::SAMPLE_W-1:0]                 rd_data;
    logic                                                run;
    logic                                                sample_stb;
    logic [la_capture_pkg::SAMPLE_W-1:0]                 sample;
    logic                                                sample_valid;
    logic                                                hit;
    logic                                                wr_en;
    logic [la_capture_pkg::BUF_AW-1:0]                   wr_addr;

    assign done_irq = done;

    apb_regs i_apb_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .arm       (arm),
        .abort     (abort),
        .mode      (mode),
        .depth     (depth),
        .pre       (pre),
        .div       (div),
        .ch_ops    (ch_ops),
        .busy      (busy),
        .triggered (triggered),
        .done      (done),
        .start_ptr (start_ptr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    sample_divider i_sample_divider (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .div        (div),
        .sample_stb (sample_stb)
    );

    trigger_unit i_trigger_unit (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample_stb   (sample_stb),
        .digital_in   (digital_in),
        .ch_ops       (ch_ops),
        .mode         (mode),
        .sample       (sample),
        .sample_valid (sample_valid),
        .hit          (hit)
    );

    capture_fsm i_capture_fsm (
        .clk          (clk),
        .arst_n       (arst_n),
        .arm          (arm),
        .abort        (abort),
        .depth        (depth),
        .pre          (pre),
        .sample_valid (sample_valid),
        .hit          (hit),
        .run          (run),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .busy         (busy),
        .triggered    (triggered),
        .done         (done),
        .start_ptr    (start_ptr)
    );

    sample_ram i_sample_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (sample),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- tb_logic_analyzer_asserts.sv
`timescale 1ns/1ps
module tb_logic_analyzer_asserts (
    input logic clk,
    input logic arst_n,
    input logic penable,
    input logic pready,
    input logic busy,
    input logic done,
    input logic done_irq
);

    a_pready_in_access : assert property (@(posedge clk) disable iff (!arst_n)
        pready |-> penable)
        else $error("pready raised outside an access phase");

    a_pready_one_cycle : assert property (@(posedge clk) disable iff (!arst_n)
        pready |=> !pready)
        else $error("pready held for more than one cycle");

    a_done_not_busy : assert property (@(posedge clk) disable iff (!arst_n)
        !(done && busy))
        else $error("done and busy high together");

    a_irq_follows_done : assert property (@(posedge clk) disable iff (!arst_n)
        done_irq == done)
        else $error("done_irq differs from done");

endmodule

bind logic_analyzer tb_logic_analyzer_asserts i_tb_logic_analyzer_asserts (.*);

//--- tb_logic_analyzer.sv
`timescale 1ns/1ps
module tb_logic_analyzer;

    localparam int N_ROWS       = 6;
    localparam int PREADY_LIMIT = 8;

    typedef struct packed {
        logic        mode;
        logic [7:0]  depth;
        logic [7:0]  pre;
        logic [7:0]  div;
        logic [23:0] ops; // channel c condition in bits 3c+2 down to 3c
        logic        expect_trig;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic [7:0]  digital_in;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        done_irq;

    row_t        rows [N_ROWS];
    logic [7:0]  words [256];
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    integer      seed;

    logic_analyzer i_logic_analyzer (
        .clk        (clk),
        .arst_n     (arst_n),
        .digital_in (digital_in),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .done_irq   (done_irq)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        digital_in <= digital_in + 8'd1; // counter input, one step per clock
    end

    function automatic row_t make_row(input logic m, input logic [7:0] depth,
                                      input logic [7:0] pre, input logic [7:0] div,
                                      input logic [23:0] ops, input logic expect_trig);
        row_t r;
        r.mode        = m;
        r.depth       = depth;
        r.pre         = pre;
        r.div         = div;
        r.ops         = ops;
        r.expect_trig = expect_trig;
        return r;
    endfunction

    // condition of a sample against the one before it
    function automatic logic cond_hit(input logic m, input logic [23:0] ops,
                                      input logic [7:0] cur, input logic [7:0] prv);
        logic       any_match;
        logic       all_match;
        logic       used;
        logic       ok;
        logic [2:0] op;
        any_match = 1'b0;
        all_match = 1'b1;
        for (int c = 0; c < 8; c++) begin
            op   = ops[3*c +: 3];
            used = 1'b1;
            ok   = 1'b0;
            case (op)
                la_capture_pkg::OP_LOW:     ok = !cur[c];
                la_capture_pkg::OP_HIGH:    ok = cur[c];
                la_capture_pkg::OP_RISING:  ok = cur[c] && !prv[c];
                la_capture_pkg::OP_FALLING: ok = !cur[c] && prv[c];
                la_capture_pkg::OP_ANYEDGE: ok = cur[c] != prv[c];
                default:                    used = 1'b0;
            endcase
            if (used) begin
                any_match = any_match | ok;
                all_match = all_match & ok;
            end
        end
        return m ? any_match : all_match;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] data, output logic err);
        int   waited;
        int   exp_wait;
        logic ready;
        exp_wait = (!wr && addr >= la_regmap_pkg::BUF_BASE
                    && addr < la_regmap_pkg::BUF_BASE + 12'h400) ? 2 : 1; // buffer reads wait once
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        ready  = 1'b0;
        waited = 0;
        while (!ready && waited < PREADY_LIMIT) begin
            @(posedge clk);
            ready = pready;
            waited++;
        end
        assert (ready) else begin
            $display("no pready within %0d cycles for address 0x%h", PREADY_LIMIT, addr);
            err_cnt++;
        end
        if (ready) begin
            check_value($sformatf("pready cycles 0x%h", addr), 32'(waited), 32'(exp_wait));
        end
        data = prdata;
        err  = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_xfer(1'b1, addr, data, unused, err);
        check_value($sformatf("pslverr write 0x%h", addr), {31'd0, err}, 32'd0);
    endtask

    task automatic reg_read(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'd0, data, err);
        check_value($sformatf("pslverr read 0x%h", addr), {31'd0, err}, 32'd0);
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        reg_read(addr, data);
        check_value($sformatf("prdata 0x%h", addr), data, exp);
    endtask

    task automatic wait_done(input int limit, output logic seen);
        int   n;
        logic last;
        n    = 0;
        seen = 1'b0;
        last = 1'b1; // done of the previous capture stays high until the arm lands
        while (!seen && n < limit) begin
            @(posedge clk);
            seen = done_irq && !last;
            last = done_irq;
            n++;
        end
    endtask

    task automatic report_test(input int idx, input string what, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %0d %s: ok", idx, what);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", idx, what, err_cnt - errs_before);
        end
    endtask

    initial begin
        int          base;
        int          limit;
        logic        seen;
        logic        err;
        logic [31:0] data;
        logic [7:0]  step;
        clk        = 1'b0;
        arst_n     = 1'b0;
        digital_in = 8'd0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        seed       = 32'ha2b5;

        rows[0] = make_row(1'b0, 8'd31, 8'd8, 8'd0, 24'h0, 1'b1);
        rows[1] = make_row(1'b0, 8'd31, 8'd8, 8'd3, 24'h0, 1'b1);
        rows[2] = make_row(1'b0, 8'd31, 8'd8, 8'($random(seed) & 32'h1f), 24'h0, 1'b1);
        // ch0 rising and ch2 high
        rows[3] = make_row(1'b0, 8'd31, 8'd8, 8'd2, (24'd3 << 0) | (24'd2 << 6), 1'b1);
        // ch7 falling or ch1 low
        rows[4] = make_row(1'b1, 8'd31, 8'd8, 8'd1, (24'd4 << 21) | (24'd1 << 3), 1'b1);
        rows[5] = make_row(1'b1, 8'd31, 8'd8, 8'd0, 24'h0, 1'b0);

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        base = err_cnt;
        read_expect(la_regmap_pkg::REG_CTRL, 32'd0);
        read_expect(la_regmap_pkg::REG_MODE, 32'd0);
        read_expect(la_regmap_pkg::REG_DEPTH, 32'd0);
        read_expect(la_regmap_pkg::REG_PRE, 32'd0);
        read_expect(la_regmap_pkg::REG_DIV, 32'd0);
        read_expect(la_regmap_pkg::REG_STATUS, 32'd0);
        for (int c = 0; c < 8; c++) begin
            read_expect(la_regmap_pkg::REG_CH_BASE + 12'(4*c), 32'd0);
        end
        reg_write(la_regmap_pkg::REG_MODE, 32'hFFFF_FFFF);
        read_expect(la_regmap_pkg::REG_MODE, 32'h1);
        reg_write(la_regmap_pkg::REG_DEPTH, 32'h1234_56A5);
        read_expect(la_regmap_pkg::REG_DEPTH, 32'hA5);
        reg_write(la_regmap_pkg::REG_PRE, 32'hCAFE_003C);
        read_expect(la_regmap_pkg::REG_PRE, 32'h3C);
        reg_write(la_regmap_pkg::REG_DIV, 32'h0000_FF81);
        read_expect(la_regmap_pkg::REG_DIV, 32'h81);
        for (int c = 0; c < 8; c++) begin
            reg_write(la_regmap_pkg::REG_CH_BASE + 12'(4*c), 32'hFFFF_FFF8 | 32'(c));
            read_expect(la_regmap_pkg::REG_CH_BASE + 12'(4*c), 32'(c));
        end
        report_test(1, "register reset and readback", base);

        for (int r = 0; r < N_ROWS; r++) begin
            base = err_cnt;
            reg_write(la_regmap_pkg::REG_MODE, {31'd0, rows[r].mode});
            reg_write(la_regmap_pkg::REG_DEPTH, {24'd0, rows[r].depth});
            reg_write(la_regmap_pkg::REG_PRE, {24'd0, rows[r].pre});
            reg_write(la_regmap_pkg::REG_DIV, {24'd0, rows[r].div});
            for (int c = 0; c < 8; c++) begin
                reg_write(la_regmap_pkg::REG_CH_BASE + 12'(4*c), {29'd0, rows[r].ops[3*c +: 3]});
            end
            reg_write(la_regmap_pkg::REG_CTRL, 32'd1);
            limit = 64 * (int'(rows[r].div) + 1) + 100;
            wait_done(limit, seen);
            if (rows[r].expect_trig) begin
                assert (seen) else begin
                    $display("capture %0d did not finish within %0d cycles", r, limit);
                    err_cnt++;
                end
                read_expect(la_regmap_pkg::REG_STATUS, 32'h6); // triggered and done
                for (int i = 0; i <= int'(rows[r].depth); i++) begin
                    reg_read(la_regmap_pkg::BUF_BASE + 12'(4*i), data);
                    words[i] = data[7:0];
                end
                check_value("done_irq", {31'd0, done_irq}, 32'd1);
                step = rows[r].div + 8'd1;
                for (int i = 1; i <= int'(rows[r].depth); i++) begin
                    check_value($sformatf("prdata word %0d step", i),
                                {24'd0, 8'(words[i] - words[i-1])}, {24'd0, step});
                end
                if (rows[r].pre != 8'd0) begin
                    check_value("hit at word PRE",
                                {31'd0, cond_hit(rows[r].mode, rows[r].ops,
                                                 words[rows[r].pre], words[rows[r].pre - 8'd1])},
                                32'd1);
                end
            end else begin
                assert (!seen) else begin
                    $display("capture %0d finished although nothing can trigger it", r);
                    err_cnt++;
                end
                read_expect(la_regmap_pkg::REG_STATUS, 32'h1); // still busy
                reg_write(la_regmap_pkg::REG_CTRL, 32'd0);
                read_expect(la_regmap_pkg::REG_STATUS, 32'h0);
            end
            report_test(r + 2, $sformatf("capture div %0d", rows[r].div), base);
        end

        base = err_cnt;
        apb_xfer(1'b0, 12'h020, 32'd0, data, err); // hole in the map
        check_value("pslverr unmapped", {31'd0, err}, 32'd1);
        apb_xfer(1'b1, la_regmap_pkg::REG_STATUS, 32'd7, data, err);
        check_value("pslverr STATUS write", {31'd0, err}, 32'd1);
        reg_write(la_regmap_pkg::REG_MODE, 32'd1);
        reg_write(la_regmap_pkg::REG_CTRL, 32'd1);
        apb_xfer(1'b0, la_regmap_pkg::BUF_BASE, 32'd0, data, err);
        check_value("pslverr busy buffer read", {31'd0, err}, 32'd1);
        reg_write(la_regmap_pkg::REG_CTRL, 32'd0);
        report_test(N_ROWS + 2, "error responses", base);

        $display("tests ok: %0d, tests failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
la_regmap_pkg.sv
la_capture_pkg.sv
apb_regs.sv
sample_divider.sv
trigger_unit.sv
capture_fsm.sv
sample_ram.sv
logic_analyzer.sv
tb_logic_analyzer_asserts.sv
tb_logic_analyzer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the logic analyzer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_logic_analyzer -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    exit 0
fi
exit 1
